// File: Makefile
TOP = operand_fetch_stage_tb

.PHONY: all run lint clean

all: run

build/V$(TOP): operand_fetch_stage.f src/*.sv bench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) --Mdir build -f operand_fetch_stage.f

run: build/V$(TOP)
	./build/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f operand_fetch_stage.f

clean:
	rm -rf build sim.log

// File: bench/operand_fetch_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch_stage_tb
	import chan_pkg::*, instr_pkg::*;
();

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	instr_t in_instr;
	logic out_valid;
	logic out_ready;
	instr_t out_instr;
	chan_write_t wb;

	instr_t rows_in[$];
	instr_t expected[$];
	string row_names[$];
	chan_data_t wb_values[$];
	chan_data_t shadow [n_channels];
	commit_id_t commit_count;

	chan_write_t wb_queue[$];
	int wb_due[$];
	chan_write_t next_wb;
	instr_t want;
	logic [31:0] rng;
	int cycle;
	int limit;
	int issue_idx;
	int out_count;
	int errors;
	bit in_fire;
	bit timed_out;

	operand_fetch_stage #(.pending_width(4)) DUT (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.out_valid(out_valid), .out_ready(out_ready), .out_instr(out_instr),
		.wb(wb)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Junk in the value fields must be replaced by the fetch.
	function automatic operand_t ch(input int n);
		return '{kind: opnd_channel, src: chan_addr_t'(n), value: 16'h7e7e};
	endfunction

	function automatic operand_t lit(input int v);
		return '{kind: opnd_imm, src: '0, value: chan_data_t'(v)};
	endfunction

	function automatic operand_t nop();
		return '{kind: opnd_none, src: '0, value: 16'h5a5a};
	endfunction

	// Reference model applied in program order as the table is built.
	task automatic add_row(input string name, input operand_t a, input operand_t b,
			input operand_t c, input bit writes, input int dest, input int value);
		instr_t instr;
		instr_t model;
		instr = '0;
		instr.operation = operation_t'(rows_in.size());
		instr.operands = {c, b, a};
		instr.writes_channel = writes;
		instr.dest = chan_addr_t'(dest);
		model = instr;
		for (int k = 0; k < 3; k++) begin
			if (instr.operands[k].kind == opnd_channel)
				model.operands[k].value = shadow[instr.operands[k].src];
			else if (instr.operands[k].kind == opnd_none)
				model.operands[k].value = '0;
		end
		if (writes) begin
			model.commit_id = commit_count;
			commit_count++;
			shadow[dest] = chan_data_t'(value);
		end
		rows_in.push_back(instr);
		expected.push_back(model);
		row_names.push_back(name);
		wb_values.push_back(chan_data_t'(value));
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b0;
		wb = '0;
		rng = 32'h8674_cb85;
		commit_count = '0;
		cycle = 0;
		issue_idx = 0;
		out_count = 0;
		errors = 0;
		in_fire = 1'b0;
		timed_out = 1'b0;
		for (int i = 0; i < n_channels; i++)
			shadow[i] = '0;

		add_row("cold_read", ch(3), ch(7), ch(12), 1, 1, 100);
		add_row("imm_all", lit(5), lit(-3), lit(1234), 0, 0, 0);
		add_row("none_all", nop(), nop(), nop(), 1, 2, -200);
		add_row("fwd_a", ch(2), lit(9), nop(), 1, 4, 321); // Reader right behind its writer.
		add_row("fwd_b", nop(), ch(4), ch(1), 1, 5, 77);
		add_row("fwd_c", lit(-1), nop(), ch(5), 1, 6, -5000);
		add_row("mix_imm_none", nop(), lit(42), nop(), 0, 0, 0);
		add_row("rewrite_1", ch(1), ch(1), ch(1), 1, 1, 555);
		add_row("read_new_1", ch(1), lit(0), ch(6), 0, 0, 0);
		add_row("self_dest", ch(7), nop(), nop(), 1, 7, 31);
		add_row("read_7", ch(7), ch(7), lit(7), 1, 8, 8);
		add_row("chain_8", ch(8), nop(), nop(), 1, 8, 16);
		add_row("chain_8b", ch(8), ch(8), nop(), 1, 8, 32);
		add_row("read_8", nop(), nop(), ch(8), 0, 0, 0);
		add_row("burst_9", lit(1), lit(2), lit(3), 1, 9, 900);
		add_row("burst_10", lit(4), nop(), lit(6), 1, 10, 1000);
		add_row("burst_11", nop(), lit(-7), nop(), 1, 11, 1100);
		add_row("sum_9_11", ch(9), ch(10), ch(11), 1, 12, -12);
		add_row("read_12", ch(12), ch(2), ch(4), 0, 0, 0);
		add_row("max_vals", lit(32767), lit(-32768), ch(15), 1, 15, 32767);
		add_row("read_15", ch(15), nop(), ch(0), 1, 0, -1);
		add_row("read_0", ch(0), ch(0), ch(0), 1, 3, 3);
		add_row("read_3", lit(11), ch(3), nop(), 0, 0, 0);
		add_row("final_mix", ch(5), ch(6), ch(1), 1, 13, 1313);
		limit = 40 * rows_in.size() + 200;

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
			errors++;
			$display("After reset out_valid is %b and in_ready is %b", out_valid, in_ready);
		end

		while (!timed_out && (out_count < rows_in.size() || wb_queue.size() > 0 || wb.enable)) begin
			@(posedge clk);
			cycle++;
			if (in_fire)
				issue_idx++;
			in_valid <= issue_idx < rows_in.size();
			if (issue_idx < rows_in.size())
				in_instr <= rows_in[issue_idx];
			rng = xorshift(rng);
			out_ready <= rng[1:0] != 2'b00;
			if (wb_queue.size() > 0 && wb_due[0] <= cycle) begin
				wb <= wb_queue.pop_front();
				wb_due.delete(0);
			end else begin
				wb <= '0;
			end

			// Settled values decide the transfers at the next edge.
			@(negedge clk);
			in_fire = in_valid && in_ready;
			if (out_valid && out_ready && out_count >= rows_in.size()) begin
				errors++;
				$display("Extra output instruction after all %0d rows came out", out_count);
			end else if (out_valid && out_ready) begin
				want = expected[out_count];
				if (out_instr.operation !== want.operation) begin
					errors++;
					$display("Fail %s operation: expected %0d, got %0d",
						row_names[out_count], want.operation, out_instr.operation);
				end
				for (int k = 0; k < 3; k++) begin
					if (out_instr.operands[k].value !== want.operands[k].value) begin
						errors++;
						$display("Fail %s operand %0d: expected %0d, got %0d", row_names[out_count],
							k, want.operands[k].value, out_instr.operands[k].value);
					end
				end
				if (out_instr.writes_channel !== want.writes_channel
						|| out_instr.dest !== want.dest) begin
					errors++;
					$display("Fail %s dest: expected %0d to %0d, got %0d to %0d",
						row_names[out_count], want.writes_channel, want.dest,
						out_instr.writes_channel, out_instr.dest);
				end
				if (out_instr.commit_id !== want.commit_id) begin
					errors++;
					$display("Fail %s commit id: expected %0d, got %0d",
						row_names[out_count], want.commit_id, out_instr.commit_id);
				end
				if (want.writes_channel) begin
					rng = xorshift(rng);
					next_wb.enable = 1'b1;
					next_wb.addr = want.dest;
					next_wb.value = wb_values[out_count];
					wb_queue.push_back(next_wb);
					wb_due.push_back(cycle + 2 + int'(rng[1:0])); // 1 to 4 cycles after the transfer.
				end
				out_count++;
			end
			if (cycle >= limit) begin
				timed_out = 1'b1;
				errors++;
				$display("Timeout after %0d cycles, only %0d of %0d rows came out",
					cycle, out_count, rows_in.size());
			end
		end

		$display("%0d errors over %0d rows in %0d cycles", errors, rows_in.size(), cycle);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: operand_fetch_stage.f
src/chan_pkg.sv
src/instr_pkg.sv
src/channel_file.sv
src/channel_scoreboard.sv
src/operand_fetch_substage.sv
src/skid_buffer.sv
src/operand_fetch_stage.sv
bench/operand_fetch_stage_tb.sv

// File: src/chan_pkg.sv
`default_nettype none

package chan_pkg;

	localparam int n_channels = 16;

	// One sample as held in a data channel.
	typedef logic signed [15:0] chan_data_t;

	typedef logic [$clog2(n_channels) - 1 : 0] chan_addr_t;

	// Writeback port, driven from the execute end of the core.
	typedef struct packed {
		logic enable;
		chan_addr_t addr;
		chan_data_t value;
	} chan_write_t;

endpackage

`default_nettype wire

// File: src/channel_file.sv
`timescale 1ns/1ns
`default_nettype none

module channel_file
	import chan_pkg::*;
(
	input wire clk,
	input wire reset,

	input wire chan_write_t wb,

	input wire chan_addr_t [2:0] rd_addr,
	output chan_data_t [2:0] rd_data
);

	chan_data_t channels [n_channels];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++) begin
				channels[i] <= '0;
			end
		end else if (wb.enable) begin
			channels[wb.addr] <= wb.value;
		end
	end

	// One asynchronous read port per substage.
	always_comb begin
		for (int k = 0; k < 3; k++) begin
			rd_data[k] = channels[rd_addr[k]];
		end
	end

endmodule

`default_nettype wire

// File: src/channel_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module channel_scoreboard
	import chan_pkg::*;
#(
	parameter int pending_width = 4
) (
	input wire clk,
	input wire reset,

	input wire add_valid,
	input wire chan_addr_t add_addr,

	input wire chan_write_t wb,

	input wire chan_addr_t query_addr,
	output logic pending,
	output logic pending_one
);

	logic [pending_width - 1 : 0] count [n_channels];

	logic [n_channels - 1 : 0] add_hit;
	logic [n_channels - 1 : 0] wb_hit;

	always_comb begin
		for (int i = 0; i < n_channels; i++) begin
			add_hit[i] = add_valid && add_addr == chan_addr_t'(i);
			wb_hit[i] = wb.enable && wb.addr == chan_addr_t'(i);
		end
	end

	// Add and writeback on the same channel cancel out.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < n_channels; i++) begin
				count[i] <= '0;
			end
		end else begin
			for (int i = 0; i < n_channels; i++) begin
				if (add_hit[i] && !wb_hit[i])
					count[i] <= count[i] + 1'b1;
				else if (wb_hit[i] && !add_hit[i])
					count[i] <= count[i] - 1'b1;
			end
		end
	end

	assign pending = count[query_addr] != '0;
	assign pending_one = count[query_addr] == pending_width'(1);

	for (genvar i = 0; i < n_channels; i++) begin : g_check
		assert property (@(posedge clk) disable iff (reset)
			add_hit[i] && count[i] == '1 |-> wb_hit[i])
			else $error("Pending count of channel %0d wrapped", i);
		assert property (@(posedge clk) disable iff (reset)
			wb_hit[i] |-> count[i] != '0)
			else $error("Writeback to channel %0d with nothing pending", i);
	end

endmodule

`default_nettype wire

// File: src/instr_pkg.sv
`default_nettype none

package instr_pkg;

	import chan_pkg::*;

	typedef enum logic [1:0] {
		opnd_none,
		opnd_channel,
		opnd_imm
	} operand_kind_t;

	// Value is the literal going in and the fetched operand coming out.
	typedef struct packed {
		operand_kind_t kind;
		chan_addr_t src;
		chan_data_t value;
	} operand_t;

	typedef logic [4:0] operation_t;

	typedef logic [7:0] commit_id_t;

	typedef struct packed {
		operation_t operation;
		operand_t [2:0] operands; // a, b and c.
		logic writes_channel;
		chan_addr_t dest;
		commit_id_t commit_id;
	} instr_t;

endpackage

`default_nettype wire

// File: src/operand_fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch_stage
	import chan_pkg::*, instr_pkg::*;
#(
	parameter int pending_width = 4
) (
	input wire clk,
	input wire reset,

	input wire in_valid,
	output logic in_ready,
	input wire instr_t in_instr,

	output logic out_valid,
	input wire out_ready,
	output instr_t out_instr,

	input wire chan_write_t wb
);

	logic [2:0] fetch_valid;
	logic [2:0] fetch_ready; // Ready seen by the output of substage k.
	instr_t [2:0] fetch_instr;

	chan_addr_t [2:0] rd_addr;
	chan_data_t [2:0] rd_data;

	channel_file channels (
		.clk(clk),
		.reset(reset),
		.wb(wb),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	operand_fetch_substage #(.operand_index(0), .pending_width(pending_width)) fetch_a (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready), .in_instr(in_instr),
		.out_valid(fetch_valid[0]), .out_ready(fetch_ready[0]), .out_instr(fetch_instr[0]),
		.wb(wb), .rd_addr(rd_addr[0]), .rd_data(rd_data[0])
	);

	operand_fetch_substage #(.operand_index(1), .pending_width(pending_width)) fetch_b (
		.clk(clk), .reset(reset),
		.in_valid(fetch_valid[0]), .in_ready(fetch_ready[0]), .in_instr(fetch_instr[0]),
		.out_valid(fetch_valid[1]), .out_ready(fetch_ready[1]), .out_instr(fetch_instr[1]),
		.wb(wb), .rd_addr(rd_addr[1]), .rd_data(rd_data[1])
	);

	// Also hands out the commit ids.
	operand_fetch_substage #(.operand_index(2), .pending_width(pending_width)) fetch_c (
		.clk(clk), .reset(reset),
		.in_valid(fetch_valid[1]), .in_ready(fetch_ready[1]), .in_instr(fetch_instr[1]),
		.out_valid(fetch_valid[2]), .out_ready(fetch_ready[2]), .out_instr(fetch_instr[2]),
		.wb(wb), .rd_addr(rd_addr[2]), .rd_data(rd_data[2])
	);

	skid_buffer skid (
		.clk(clk),
		.reset(reset),
		.in_valid(fetch_valid[2]),
		.in_ready(fetch_ready[2]),
		.in_instr(fetch_instr[2]),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_instr(out_instr)
	);

endmodule

`default_nettype wire

// File: src/operand_fetch_substage.sv
`timescale 1ns/1ns
`default_nettype none

module operand_fetch_substage
	import chan_pkg::*, instr_pkg::*;
#(
	parameter int operand_index = 0,
	parameter int pending_width = 4
) (
	input wire clk,
	input wire reset,

	input wire in_valid,
	output logic in_ready,
	input wire instr_t in_instr,

	output logic out_valid,
	input wire out_ready,
	output instr_t out_instr,

	input wire chan_write_t wb,

	output chan_addr_t rd_addr,
	input wire chan_data_t rd_data
);

	typedef enum logic {
		idle,
		hold
	} state_t;

	localparam bit stamps_commit = (operand_index == 2);

	state_t state;
	instr_t held;
	instr_t live_instr;
	instr_t fetched;
	operand_t live_op;
	chan_data_t opnd_value;
	commit_id_t next_commit;

	logic pending;
	logic pending_one;
	logic forward;
	logic resolved;
	logic out_free;
	logic take;
	logic capture;
	logic send;

	// While holding, the latched instruction drives the fetch logic.
	assign live_instr = (state == hold) ? held : in_instr;
	assign live_op = live_instr.operands[operand_index];
	assign rd_addr = live_op.src;

	channel_scoreboard #(
		.pending_width(pending_width)
	) scoreboard (
		.clk(clk),
		.reset(reset),
		.add_valid(send && live_instr.writes_channel),
		.add_addr(live_instr.dest),
		.wb(wb),
		.query_addr(live_op.src),
		.pending(pending),
		.pending_one(pending_one)
	);

	// Last outstanding write lands this cycle.
	assign forward = pending_one && wb.enable && wb.addr == live_op.src;
	assign resolved = live_op.kind != opnd_channel || !pending || forward;

	assign out_free = !out_valid || out_ready;
	assign in_ready = state == idle && out_free;
	assign take = in_valid && in_ready;
	assign capture = take && !resolved;
	assign send = resolved && out_free && (state == hold || in_valid);

	always_comb begin
		case (live_op.kind)
			opnd_imm: opnd_value = live_op.value;
			opnd_channel: opnd_value = forward ? wb.value : rd_data;
			default: opnd_value = '0;
		endcase
	end

	always_comb begin
		fetched = live_instr;
		fetched.operands[operand_index].value = opnd_value;
		if (stamps_commit && live_instr.writes_channel)
			fetched.commit_id = next_commit;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			out_valid <= 1'b0;
			next_commit <= '0;
		end else begin
			case (state)
				idle: if (capture) state <= hold;
				hold: if (send) state <= idle;
				default: state <= idle;
			endcase

			if (send)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;

			if (stamps_commit && send && live_instr.writes_channel)
				next_commit <= next_commit + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			held <= in_instr;
		if (send)
			out_instr <= fetched;
	end

	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_instr))
		else $error("Substage %0d changed a stalled output", operand_index);

endmodule

`default_nettype wire

// File: src/skid_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module skid_buffer
	import instr_pkg::*;
(
	input wire clk,
	input wire reset,

	input wire in_valid,
	output logic in_ready,
	input wire instr_t in_instr,

	output logic out_valid,
	input wire out_ready,
	output instr_t out_instr
);

	logic main_valid;
	logic skid_valid;
	instr_t main_instr;
	instr_t skid_instr;

	// Straight off a flop so nothing combinational reaches upstream.
	assign in_ready = !skid_valid;
	assign out_valid = main_valid;
	assign out_instr = main_instr;

	always_ff @(posedge clk) begin
		if (reset) begin
			main_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (!main_valid || out_ready) begin
			if (skid_valid) begin
				main_valid <= 1'b1;
				skid_valid <= 1'b0;
			end else begin
				main_valid <= in_valid;
			end
		end else if (in_valid && in_ready) begin
			skid_valid <= 1'b1; // Main is stalled.
		end
	end

	always_ff @(posedge clk) begin
		if (!main_valid || out_ready)
			main_instr <= skid_valid ? skid_instr : in_instr;
		else if (in_valid && in_ready)
			skid_instr <= in_instr;
	end

	// With both registers full and no drain, the waiting item stays put.
	assert property (@(posedge clk) disable iff (reset)
		main_valid && skid_valid && !out_ready |=> skid_valid && $stable(skid_instr))
		else $error("Skid buffer accepted while full");

endmodule

`default_nettype wire
